// File: sim.f
udp_rx_pkg.sv
frame_stream_if.sv
udp_header_parser.sv
crc32_checker.sv
slot_router.sv
udp_frame_receiver.sv
udp_frame_receiver_tb.sv

// File: udp_rx_trace.txt
// Header: slot mask, byte count, verdict (0 none 1 good 2 bad), abort, fcs; then the bytes
// With fcs set the last four bytes are XORed onto the FCS computed over the frame
// Good frame, 18 byte payload
6 40 1 0 1
02 00 00 00 00 01 02 00 00 00 00 02 08 00 45 00
00 2e 12 34 40 00 40 11 b7 7c c0 a8 01 0a c0 a8
01 14 30 39 1f 90 00 1a 00 00 10 11 12 13 14 15
16 17 18 19 1a 1b 1c 1d 1e 1f 20 21 00 00 00 00
// Short frame with padding
3 40 1 0 1
02 00 00 00 00 01 02 00 00 00 00 02 08 00 45 00
00 20 12 35 40 00 40 11 b7 7c c0 a8 01 0a c0 a8
01 14 30 39 23 28 00 0c 00 00 a1 a2 a3 a4 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
// Corrupted FCS
3 40 2 0 1
02 00 00 00 00 01 02 00 00 00 00 02 08 00 45 00
00 2e 12 36 40 00 40 11 b7 7c c0 a8 01 0a c0 a8
01 14 30 39 1f 91 00 1a 00 00 30 31 32 33 34 35
36 37 38 39 3a 3b 3c 3d 3e 3f 40 41 00 00 80 00
// Dropped: IPv6 EtherType, TCP protocol, more-fragments set
f 10 0 0 0
02 00 00 00 00 01 02 00 00 00 00 02 86 dd 60 00
f 20 0 0 0
02 00 00 00 00 01 02 00 00 00 00 02 08 00 45 00
00 2e 12 37 40 00 40 06 b7 7c c0 a8 01 0a c0 a8
f 20 0 0 0
02 00 00 00 00 01 02 00 00 00 00 02 08 00 45 00
00 2e 12 38 20 00 40 11 b7 7c c0 a8 01 0a c0 a8
// No slot enabled
0 40 0 0 1
02 00 00 00 00 01 02 00 00 00 00 02 08 00 45 00
00 2e 12 3b 40 00 40 11 b7 7c c0 a8 01 0a c0 a8
01 14 30 39 1f 92 00 1a 00 00 70 71 72 73 74 75
76 77 78 79 7a 7b 7c 7d 7e 7f 80 81 00 00 00 00
// Cut short by the next frame
1 1e 2 1 0
02 00 00 00 00 01 02 00 00 00 00 02 08 00 45 00
00 2e 12 39 40 00 40 11 b7 7c c0 a8 01 0a
8 42 1 0 1
02 00 00 00 00 01 02 00 00 00 00 02 08 00 45 00
00 30 12 3a 40 00 40 11 b7 7c c0 a8 01 0a c0 a8
01 14 30 39 13 88 00 1c 00 00 50 51 52 53 54 55
56 57 58 59 5a 5b 5c 5d 5e 5f 60 61 62 63 00 00
00 00
0 0 0 0 0

// File: udp_frame_receiver_tb.sv
`timescale 1ns/10ps

module udp_frame_receiver_tb;

    localparam int TRACE_WORDS = 1024;
    localparam int MAX_FRAME   = 128;

    logic                   clock;
    logic                   reset_n;
    udp_rx_pkg::byte_t      rx_data;
    logic                   rx_valid;
    logic                   rx_first;
    udp_rx_pkg::slot_mask_t slot_enable;
    udp_rx_pkg::byte_t      packet_data;
    udp_rx_pkg::slot_mask_t packet_valid;
    udp_rx_pkg::slot_mask_t good_packet;
    udp_rx_pkg::slot_mask_t bad_packet;
    udp_rx_pkg::field16_t   udp_destination;

    logic [15:0] trace_mem [0:TRACE_WORDS-1];
    logic [7:0]  frame [0:MAX_FRAME-1];
    // Mask and data per forwarded byte, good flag and mask per verdict
    logic [11:0] byte_queue [$];
    logic [4:0]  verdict_queue [$];
    logic [11:0] expected_byte;
    logic [4:0]  expected_verdict;
    logic [3:0]  expected_good;
    logic [3:0]  expected_bad;

    logic [3:0]  frame_mask;
    int          frame_count;
    int          verdict_code;
    logic        frame_abort;
    logic        frame_fcs;
    logic [31:0] lcg_state;
    int          cycle_count    = 0;
    int          cycle_limit    = 0;
    int          error_count    = 0;
    int          records_passed = 0;
    int          records_failed = 0;

    udp_frame_receiver u_dut (
        .clock           (clock),
        .reset_n         (reset_n),
        .rx_data         (rx_data),
        .rx_valid        (rx_valid),
        .rx_first        (rx_first),
        .slot_enable     (slot_enable),
        .packet_data     (packet_data),
        .packet_valid    (packet_valid),
        .good_packet     (good_packet),
        .bad_packet      (bad_packet),
        .udp_destination (udp_destination)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    // Reflected CRC-32, one data bit per step
    function automatic logic [31:0] crc_step(logic [31:0] crc, logic [7:0] value);
        logic [31:0] result;
        logic        feedback;
        result = crc;
        for (int bit_index = 0; bit_index < 8; bit_index++) begin
            feedback = result[0] ^ value[bit_index];
            result   = result >> 1;
            if (feedback) begin
                result = result ^ 32'hEDB88320;
            end
        end
        return result;
    endfunction

    function automatic int next_gap();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[17:16]);
    endfunction

    task automatic load_frame(input int position);
        logic [31:0] crc;
        logic [31:0] fcs;
        int          data_bytes;
        frame_mask   = trace_mem[position][3:0];
        frame_count  = trace_mem[position + 1];
        verdict_code = trace_mem[position + 2];
        frame_abort  = trace_mem[position + 3][0];
        frame_fcs    = trace_mem[position + 4][0];
        for (int i = 0; i < frame_count; i++) begin
            frame[i] = trace_mem[position + 5 + i][7:0];
        end
        // Trace FCS bytes flip bits of the true FCS
        if (frame_fcs) begin
            data_bytes = frame_count - 4;
            crc        = 32'hFFFFFFFF;
            for (int i = 0; i < data_bytes; i++) begin
                crc = crc_step(crc, frame[i]);
            end
            fcs = ~crc;
            for (int i = 0; i < 4; i++) begin
                frame[data_bytes + i] = frame[data_bytes + i] ^ fcs[8*i +: 8];
            end
        end
    endtask

    task automatic predict_outputs();
        int         slot;
        int         forward_end;
        logic [3:0] expected_mask;
        slot = 0;
        for (int i = 0; i < 4; i++) begin
            if (frame_mask[i]) begin
                slot = i;
            end
        end
        expected_mask = 4'b0001 << slot;
        if (verdict_code != 0) begin
            // Addresses, UDP header and payload end at 14 plus total length
            forward_end = 14 + {frame[16], frame[17]};
            if (forward_end > frame_count) begin
                forward_end = frame_count;
            end
            for (int i = 26; i < forward_end; i++) begin
                byte_queue.push_back({expected_mask, frame[i]});
            end
            verdict_queue.push_back({verdict_code == 1, expected_mask});
        end
    endtask

    task automatic drive_frame();
        int gap;
        for (int i = 0; i < frame_count; i++) begin
            @(negedge clock);
            rx_valid = 1'b1;
            rx_first = (i == 0);
            rx_data  = frame[i];
            if (i == 0) begin
                slot_enable = frame_mask;
            end
            gap = next_gap();
            repeat (gap) begin
                @(negedge clock);
                rx_valid = 1'b0;
                rx_first = 1'b0;
            end
        end
        @(negedge clock);
        rx_valid = 1'b0;
        rx_first = 1'b0;
    endtask

    task automatic wait_for_outputs(input int index);
        int waited;
        waited = 0;
        while ((byte_queue.size() != 0 || verdict_queue.size() != 0 || waited < 4) &&
               waited < 16) begin
            @(posedge clock);
            waited++;
        end
        if (verdict_queue.size() != 0) begin
            $display("record %0d: %0d verdict pulse(s) never arrived", index,
                     verdict_queue.size());
            error_count++;
            verdict_queue.delete();
        end
        if (byte_queue.size() != 0) begin
            $display("record %0d: %0d forwarded byte(s) never arrived", index, byte_queue.size());
            error_count++;
            byte_queue.delete();
        end
    endtask

    task automatic report_record(input int index, input logic [3:0] mask, input int bytes,
                                 input logic passed);
        if (passed) begin
            records_passed++;
        end else begin
            records_failed++;
        end
        $display("record %0d mask %h bytes %0d: %s", index, mask, bytes,
                 passed ? "ok" : "FAILED");
    endtask

    ////////////////////////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (reset_n) begin
            if (packet_valid != '0) begin
                if (byte_queue.size() == 0) begin
                    $display("forwarded byte %h on slot mask %h when none was expected",
                             packet_data, packet_valid);
                    error_count++;
                end else begin
                    expected_byte = byte_queue.pop_front();
                    if (packet_valid !== expected_byte[11:8]) begin
                        $display("CHECK FAILED packet_valid expected %h actual %h",
                                 expected_byte[11:8], packet_valid);
                        error_count++;
                    end
                    if (packet_data !== expected_byte[7:0]) begin
                        $display("CHECK FAILED packet_data expected %h actual %h",
                                 expected_byte[7:0], packet_data);
                        error_count++;
                    end
                end
            end
            if (good_packet != '0 || bad_packet != '0) begin
                if (verdict_queue.size() == 0) begin
                    $display("verdict pulse good %h bad %h when none was expected",
                             good_packet, bad_packet);
                    error_count++;
                end else begin
                    expected_verdict = verdict_queue.pop_front();
                    expected_good = expected_verdict[4] ? expected_verdict[3:0] : 4'h0;
                    expected_bad  = expected_verdict[4] ? 4'h0 : expected_verdict[3:0];
                    if (good_packet !== expected_good) begin
                        $display("CHECK FAILED good_packet expected %h actual %h",
                                 expected_good, good_packet);
                        error_count++;
                    end
                    if (bad_packet !== expected_bad) begin
                        $display("CHECK FAILED bad_packet expected %h actual %h",
                                 expected_bad, bad_packet);
                        error_count++;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Trace playback
    ////////////////////////////////////////////////////////////

    initial begin
        int         position;
        int         record_index;
        int         record_total;
        int         total_bytes;
        int         group_start;
        int         pending_index;
        int         pending_count;
        logic [3:0] pending_mask;
        reset_n     = 1'b0;
        rx_data     = '0;
        rx_valid    = 1'b0;
        rx_first    = 1'b0;
        slot_enable = '0;
        lcg_state   = 32'd30675;
        $readmemh("udp_rx_trace.txt", trace_mem);

        // Records end at a header with a zero byte count
        position     = 0;
        record_total = 0;
        total_bytes  = 0;
        while (!$isunknown(trace_mem[position + 1]) && trace_mem[position + 1] != 16'h0) begin
            total_bytes  = total_bytes + trace_mem[position + 1];
            record_total = record_total + 1;
            position     = position + 5 + trace_mem[position + 1];
        end
        cycle_limit = total_bytes * 4 + 20 * record_total;
        if (record_total == 0) begin
            $display("no frame records found in udp_rx_trace.txt");
            error_count++;
        end

        repeat (10) @(negedge clock);
        reset_n = 1'b1;

        position      = 0;
        group_start   = 0;
        pending_index = -1;
        pending_count = 0;
        pending_mask  = '0;
        for (record_index = 0; record_index < record_total; record_index++) begin
            load_frame(position);
            if (pending_index < 0) begin
                group_start = error_count;
            end
            predict_outputs();
            drive_frame();
            if (frame_abort) begin
                // Verdict lands with the next record's first byte
                pending_index = record_index;
                pending_mask  = frame_mask;
                pending_count = frame_count;
            end else begin
                wait_for_outputs(record_index);
                if (verdict_code == 1 && udp_destination !== {frame[36], frame[37]}) begin
                    $display("CHECK FAILED udp_destination expected %h actual %h",
                             {frame[36], frame[37]}, udp_destination);
                    error_count++;
                end
                if (pending_index >= 0) begin
                    report_record(pending_index, pending_mask, pending_count,
                                  error_count == group_start);
                    pending_index = -1;
                end
                report_record(record_index, frame_mask, frame_count, error_count == group_start);
            end
            position = position + 5 + frame_count;
        end

        $display("records passed %0d, records failed %0d, check errors %0d",
                 records_passed, records_failed, error_count);
        if (error_count == 0 && records_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: udp_frame_receiver.sv
`timescale 1ns/10ps

module udp_frame_receiver (
    input  logic                   clock,
    input  logic                   reset_n,
    input  udp_rx_pkg::byte_t      rx_data,
    input  logic                   rx_valid,
    input  logic                   rx_first,
    input  udp_rx_pkg::slot_mask_t slot_enable,
    output udp_rx_pkg::byte_t      packet_data,
    output udp_rx_pkg::slot_mask_t packet_valid,
    output udp_rx_pkg::slot_mask_t good_packet,
    output udp_rx_pkg::slot_mask_t bad_packet,
    output udp_rx_pkg::field16_t   udp_destination
);

    logic crc_done;
    logic crc_ok;

    frame_stream_if u_stream ();

    udp_header_parser u_parser (
        .clock           (clock),
        .reset_n         (reset_n),
        .rx_data         (rx_data),
        .rx_valid        (rx_valid),
        .rx_first        (rx_first),
        .stream          (u_stream.source),
        .udp_destination (udp_destination)
    );

    crc32_checker u_crc (
        .clock    (clock),
        .reset_n  (reset_n),
        .stream   (u_stream.listen),
        .crc_done (crc_done),
        .crc_ok   (crc_ok)
    );

    slot_router u_router (
        .clock        (clock),
        .reset_n      (reset_n),
        .stream       (u_stream.listen),
        .crc_done     (crc_done),
        .crc_ok       (crc_ok),
        .slot_enable  (slot_enable),
        .packet_data  (packet_data),
        .packet_valid (packet_valid),
        .good_packet  (good_packet),
        .bad_packet   (bad_packet)
    );

endmodule

// File: slot_router.sv
`timescale 1ns/10ps

module slot_router (
    input  logic                   clock,
    input  logic                   reset_n,
    frame_stream_if.listen         stream,
    input  logic                   crc_done,
    input  logic                   crc_ok,
    input  udp_rx_pkg::slot_mask_t slot_enable,
    output udp_rx_pkg::byte_t      packet_data,
    output udp_rx_pkg::slot_mask_t packet_valid,
    output udp_rx_pkg::slot_mask_t good_packet,
    output udp_rx_pkg::slot_mask_t bad_packet
);

    typedef logic [udp_rx_pkg::SLOT_INDEX_WIDTH-1:0] slot_index_t;

    slot_index_t            selected_slot;
    slot_index_t            active_slot;
    logic                   slot_armed;
    udp_rx_pkg::slot_mask_t active_mask;

    // Highest enabled slot wins
    always_comb begin
        selected_slot = '0;
        for (int slot = 0; slot < udp_rx_pkg::RECEIVE_SLOTS; slot++) begin
            if (slot_enable[slot]) begin
                selected_slot = slot_index_t'(slot);
            end
        end
    end

    assign active_mask = slot_armed ? udp_rx_pkg::slot_mask_t'(1) << active_slot : '0;

    // Old slot still latched when a verdict meets the next first byte
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            active_slot  <= '0;
            slot_armed   <= 1'b0;
            packet_valid <= '0;
            good_packet  <= '0;
            bad_packet   <= '0;
        end else begin
            packet_valid <= (stream.valid && stream.forward) ? active_mask : '0;
            good_packet  <= (crc_done && crc_ok) ? active_mask : '0;
            bad_packet   <= ((crc_done && !crc_ok) || (stream.valid && stream.abort)) ?
                            active_mask : '0;
            if (stream.valid && stream.first) begin
                active_slot <= selected_slot;
                slot_armed  <= |slot_enable;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (stream.valid && stream.forward) begin
            packet_data <= stream.data;
        end
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        $onehot0(packet_valid) && $onehot0(good_packet) && $onehot0(bad_packet));

    // CRC verdict and abort never land together
    assert property (@(posedge clock) disable iff (!reset_n)
        !(|good_packet && |bad_packet));

endmodule

// File: crc32_checker.sv
`timescale 1ns/10ps

module crc32_checker (
    input  logic           clock,
    input  logic           reset_n,
    frame_stream_if.listen stream,
    output logic           crc_done,
    output logic           crc_ok
);

    logic [31:0] crc_register;
    logic [31:0] crc_seed;
    logic [31:0] crc_updated;

    // One byte, LSB first
    function automatic logic [31:0] crc_byte(logic [31:0] crc, udp_rx_pkg::byte_t data);
        logic [31:0] value;
        int          bit_index;
        value = crc ^ {24'd0, data};
        for (bit_index = 0; bit_index < 8; bit_index++) begin
            if (value[0]) begin
                value = (value >> 1) ^ udp_rx_pkg::CRC32_POLYNOMIAL;
            end else begin
                value = value >> 1;
            end
        end
        return value;
    endfunction

    // Restart from all ones on every first byte, aborts included
    assign crc_seed    = stream.first ? '1 : crc_register;
    assign crc_updated = crc_byte(crc_seed, stream.data);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            crc_register <= '1;
            crc_done     <= 1'b0;
            crc_ok       <= 1'b0;
        end else begin
            crc_done <= stream.valid && stream.last;
            if (stream.valid) begin
                crc_register <= crc_updated;
            end
            if (stream.valid && stream.last) begin
                crc_ok <= (crc_updated == udp_rx_pkg::CRC32_RESIDUE);
            end
        end
    end

    assert property (@(posedge clock) disable iff (!reset_n)
        crc_done |-> $past(stream.valid && stream.last));

endmodule

// File: udp_header_parser.sv
`timescale 1ns/10ps

module udp_header_parser (
    input  logic                 clock,
    input  logic                 reset_n,
    input  udp_rx_pkg::byte_t    rx_data,
    input  logic                 rx_valid,
    input  logic                 rx_first,
    frame_stream_if.source       stream,
    output udp_rx_pkg::field16_t udp_destination
);

    udp_rx_pkg::parse_state_t state;
    udp_rx_pkg::parse_state_t next_state;
    udp_rx_pkg::field16_t     field_count;
    udp_rx_pkg::field16_t     next_count;
    udp_rx_pkg::field16_t     total_length;
    udp_rx_pkg::field16_t     header_bytes;
    udp_rx_pkg::field16_t     payload_bytes;
    udp_rx_pkg::field16_t     pad_bytes;
    udp_rx_pkg::field16_t     field_value;
    udp_rx_pkg::byte_t        previous_byte;
    logic                     in_frame;
    logic                     byte_accepted;
    logic                     field_byte;
    logic                     field_end;
    logic                     forward_field;

    function automatic udp_rx_pkg::field16_t count_for(int bytes);
        return udp_rx_pkg::field16_t'(bytes - 1);
    endfunction

    assign in_frame      = (state != udp_rx_pkg::S_IDLE) && (state != udp_rx_pkg::S_DROP);
    assign byte_accepted = rx_valid && (rx_first || in_frame);
    assign field_byte    = byte_accepted && !rx_first;
    assign field_end     = field_byte && (field_count == '0);
    // Two-byte fields arrive high byte first
    assign field_value   = {previous_byte, rx_data};

    assign header_bytes  = udp_rx_pkg::field16_t'(udp_rx_pkg::IPV4_HEADER_BYTES +
                                                  udp_rx_pkg::UDP_HEADER_BYTES);
    assign payload_bytes = total_length - header_bytes;
    assign pad_bytes     = (total_length < udp_rx_pkg::MIN_IPV4_TOTAL_LENGTH) ?
                           udp_rx_pkg::MIN_IPV4_TOTAL_LENGTH - total_length : '0;

    assign forward_field = state inside {udp_rx_pkg::S_IPV4_SOURCE_ADDRESS,
                                         udp_rx_pkg::S_IPV4_DESTINATION_ADDRESS,
                                         udp_rx_pkg::S_UDP_SOURCE_PORT,
                                         udp_rx_pkg::S_UDP_DESTINATION_PORT,
                                         udp_rx_pkg::S_UDP_LENGTH,
                                         udp_rx_pkg::S_UDP_CHECKSUM,
                                         udp_rx_pkg::S_UDP_PAYLOAD};

    ////////////////////////////////////////////////////////////
    // Field sequencing
    ////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        next_count = field_count - 1'b1;
        if (rx_valid && rx_first) begin
            // First byte already belongs to the destination MAC
            next_state = udp_rx_pkg::S_MAC_DESTINATION;
            next_count = count_for(udp_rx_pkg::MAC_ADDRESS_BYTES - 1);
        end else if (field_end) begin
            case (state)
                udp_rx_pkg::S_MAC_DESTINATION: begin
                    next_state = udp_rx_pkg::S_MAC_SOURCE;
                    next_count = count_for(udp_rx_pkg::MAC_ADDRESS_BYTES);
                end
                udp_rx_pkg::S_MAC_SOURCE: begin
                    next_state = udp_rx_pkg::S_ETHER_TYPE;
                    next_count = count_for(udp_rx_pkg::ETHER_TYPE_BYTES);
                end
                udp_rx_pkg::S_ETHER_TYPE: begin
                    next_state = udp_rx_pkg::S_IPV4_VERSION;
                    next_count = count_for(1);
                    if (field_value != udp_rx_pkg::IPV4_ETHER_TYPE) begin
                        next_state = udp_rx_pkg::S_DROP;
                    end
                end
                udp_rx_pkg::S_IPV4_VERSION: begin
                    next_state = udp_rx_pkg::S_IPV4_SERVICES;
                    next_count = count_for(1);
                    if (rx_data[3:0] != udp_rx_pkg::IPV4_HEADER_WORDS) begin
                        next_state = udp_rx_pkg::S_DROP;
                    end
                end
                udp_rx_pkg::S_IPV4_SERVICES: begin
                    next_state = udp_rx_pkg::S_IPV4_TOTAL_LENGTH;
                    next_count = count_for(2);
                end
                udp_rx_pkg::S_IPV4_TOTAL_LENGTH: begin
                    next_state = udp_rx_pkg::S_IPV4_IDENTIFICATION;
                    next_count = count_for(2);
                    // Too short to hold the UDP header
                    if (field_value < header_bytes) begin
                        next_state = udp_rx_pkg::S_DROP;
                    end
                end
                udp_rx_pkg::S_IPV4_IDENTIFICATION: begin
                    next_state = udp_rx_pkg::S_IPV4_FLAGS;
                    next_count = count_for(2);
                end
                udp_rx_pkg::S_IPV4_FLAGS: begin
                    next_state = udp_rx_pkg::S_IPV4_TIME_TO_LIVE;
                    next_count = count_for(1);
                    // More-fragments or offset set
                    if (field_value[13:0] != '0) begin
                        next_state = udp_rx_pkg::S_DROP;
                    end
                end
                udp_rx_pkg::S_IPV4_TIME_TO_LIVE: begin
                    next_state = udp_rx_pkg::S_IPV4_PROTOCOL;
                    next_count = count_for(1);
                end
                udp_rx_pkg::S_IPV4_PROTOCOL: begin
                    next_state = udp_rx_pkg::S_IPV4_HEADER_CHECKSUM;
                    next_count = count_for(2);
                    if (rx_data != udp_rx_pkg::IPV4_PROTOCOL_UDP) begin
                        next_state = udp_rx_pkg::S_DROP;
                    end
                end
                udp_rx_pkg::S_IPV4_HEADER_CHECKSUM: begin
                    next_state = udp_rx_pkg::S_IPV4_SOURCE_ADDRESS;
                    next_count = count_for(4);
                end
                udp_rx_pkg::S_IPV4_SOURCE_ADDRESS: begin
                    next_state = udp_rx_pkg::S_IPV4_DESTINATION_ADDRESS;
                    next_count = count_for(4);
                end
                udp_rx_pkg::S_IPV4_DESTINATION_ADDRESS: begin
                    next_state = udp_rx_pkg::S_UDP_SOURCE_PORT;
                    next_count = count_for(2);
                end
                udp_rx_pkg::S_UDP_SOURCE_PORT: begin
                    next_state = udp_rx_pkg::S_UDP_DESTINATION_PORT;
                    next_count = count_for(2);
                end
                udp_rx_pkg::S_UDP_DESTINATION_PORT: begin
                    next_state = udp_rx_pkg::S_UDP_LENGTH;
                    next_count = count_for(2);
                end
                udp_rx_pkg::S_UDP_LENGTH: begin
                    next_state = udp_rx_pkg::S_UDP_CHECKSUM;
                    next_count = count_for(2);
                end
                udp_rx_pkg::S_UDP_CHECKSUM, udp_rx_pkg::S_UDP_PAYLOAD: begin
                    // Payload, then padding if any, then FCS
                    if (state == udp_rx_pkg::S_UDP_CHECKSUM && payload_bytes != '0) begin
                        next_state = udp_rx_pkg::S_UDP_PAYLOAD;
                        next_count = payload_bytes - 1'b1;
                    end else if (pad_bytes != '0) begin
                        next_state = udp_rx_pkg::S_PAD;
                        next_count = pad_bytes - 1'b1;
                    end else begin
                        next_state = udp_rx_pkg::S_FCS;
                        next_count = count_for(udp_rx_pkg::FCS_BYTES);
                    end
                end
                udp_rx_pkg::S_PAD: begin
                    next_state = udp_rx_pkg::S_FCS;
                    next_count = count_for(udp_rx_pkg::FCS_BYTES);
                end
                default: begin
                    next_state = udp_rx_pkg::S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state           <= udp_rx_pkg::S_IDLE;
            field_count     <= '0;
            udp_destination <= '0;
            stream.valid    <= 1'b0;
            stream.first    <= 1'b0;
            stream.last     <= 1'b0;
            stream.forward  <= 1'b0;
            stream.abort    <= 1'b0;
        end else begin
            stream.valid   <= byte_accepted;
            stream.first   <= rx_valid && rx_first;
            stream.abort   <= rx_valid && rx_first && in_frame;
            stream.last    <= field_end && (state == udp_rx_pkg::S_FCS);
            stream.forward <= field_byte && forward_field;
            if (byte_accepted) begin
                state       <= next_state;
                field_count <= next_count;
            end
            if (field_end && state == udp_rx_pkg::S_UDP_DESTINATION_PORT) begin
                udp_destination <= field_value;
            end
        end
    end

    always_ff @(posedge clock) begin
        stream.data <= rx_data;
        if (byte_accepted) begin
            previous_byte <= rx_data;
        end
        if (field_end && state == udp_rx_pkg::S_IPV4_TOTAL_LENGTH) begin
            total_length <= field_value;
        end
    end

    // A completed frame never doubles as an aborted one
    assert property (@(posedge clock) disable iff (!reset_n)
        !(stream.last && stream.abort));

    // Final FCS byte hands the parser back to idle
    assert property (@(posedge clock) disable iff (!reset_n)
        stream.last |-> stream.valid && state == udp_rx_pkg::S_IDLE);

endmodule

// File: frame_stream_if.sv
`timescale 1ns/10ps

interface frame_stream_if;

    udp_rx_pkg::byte_t data;
    logic              valid;
    logic              first;
    logic              last;
    logic              forward;
    // Frame in progress cut short by a new first byte
    logic              abort;

    modport source (
        output data, valid, first, last, forward, abort
    );

    modport listen (
        input data, valid, first, last, forward, abort
    );

endinterface

// File: udp_rx_pkg.sv
package udp_rx_pkg;

    ////////////////////////////////////////////////////////////
    // Receive slots and common types
    ////////////////////////////////////////////////////////////

    localparam int RECEIVE_SLOTS    = 4;
    localparam int SLOT_INDEX_WIDTH = $clog2(RECEIVE_SLOTS);

    typedef logic [7:0]               byte_t;
    typedef logic [15:0]              field16_t;
    typedef logic [RECEIVE_SLOTS-1:0] slot_mask_t;

    ////////////////////////////////////////////////////////////
    // Ethernet, IPv4 and UDP
    ////////////////////////////////////////////////////////////

    localparam field16_t   IPV4_ETHER_TYPE   = 16'h0800;
    localparam byte_t      IPV4_PROTOCOL_UDP = 8'h11;
    // No options accepted
    localparam logic [3:0] IPV4_HEADER_WORDS = 4'd5;

    // Field sizes in bytes
    localparam int MAC_ADDRESS_BYTES = 6;
    localparam int ETHER_TYPE_BYTES  = 2;
    localparam int IPV4_HEADER_BYTES = 20;
    localparam int UDP_HEADER_BYTES  = 8;
    localparam int FCS_BYTES         = 4;

    // Shorter packets get padded up to this length
    localparam field16_t MIN_IPV4_TOTAL_LENGTH = 16'd46;

    ////////////////////////////////////////////////////////////
    // CRC-32, reflected form
    ////////////////////////////////////////////////////////////

    localparam logic [31:0] CRC32_POLYNOMIAL = 32'hEDB88320;
    // Left in the register after a good frame and its FCS
    localparam logic [31:0] CRC32_RESIDUE    = 32'hDEBB20E3;

    typedef enum logic [4:0] {
        S_IDLE,
        S_MAC_DESTINATION,
        S_MAC_SOURCE,
        S_ETHER_TYPE,
        S_IPV4_VERSION,
        S_IPV4_SERVICES,
        S_IPV4_TOTAL_LENGTH,
        S_IPV4_IDENTIFICATION,
        S_IPV4_FLAGS,
        S_IPV4_TIME_TO_LIVE,
        S_IPV4_PROTOCOL,
        S_IPV4_HEADER_CHECKSUM,
        S_IPV4_SOURCE_ADDRESS,
        S_IPV4_DESTINATION_ADDRESS,
        S_UDP_SOURCE_PORT,
        S_UDP_DESTINATION_PORT,
        S_UDP_LENGTH,
        S_UDP_CHECKSUM,
        S_UDP_PAYLOAD,
        S_PAD,
        S_FCS,
        S_DROP
    } parse_state_t;

endpackage
